/* common/lite_subsys_macros.svh */
// ----------------------------------------------------------------------
// Bus widths, mailbox depth and address map of the lite subsystem
// ----------------------------------------------------------------------

`ifndef LITE_SUBSYS_MACROS_SVH
`define LITE_SUBSYS_MACROS_SVH

// Register bus widths
`define LITE_ADDR_W 32
`define LITE_DATA_W 32

// Words held by each mailbox FIFO
`define MBOX_DEPTH 8

// Four consecutive windows of WIN_SIZE bytes starting at WIN_BASE
// Window 0 cfg port, 1 h2c mailbox, 2 c2h mailbox, 3 doorbell
`define WIN_BASE 32'h1040_0000
`define WIN_SIZE 32'h0000_1000

`endif

/* common/lite_subsys_pkg.sv */
// ----------------------------------------------------------------------
// Types shared by the lite subsystem
// Address and data words, request and response structs, crossbar FSM
// ----------------------------------------------------------------------

`default_nettype none

`include "lite_subsys_macros.svh"

package lite_subsys_pkg;

  typedef logic [`LITE_ADDR_W-1:0] lite_addr_t;
  typedef logic [`LITE_DATA_W-1:0] lite_data_t;

  // Byte offset inside one address window
  typedef logic [$clog2(`WIN_SIZE)-1:0] win_off_t;

  // Selected window, 0 to 3
  typedef logic [1:0] tgt_idx_t;

  // Initiator side of a link
  typedef struct packed {
    logic       req_valid;
    logic       write;
    lite_addr_t addr;
    lite_data_t wdata;
    logic       rsp_ready;
  } lite_req_t;

  // Target side of a link
  typedef struct packed {
    logic       req_ready;
    logic       rsp_valid;
    lite_data_t rdata;
    logic       err;
  } lite_rsp_t;

  typedef enum logic [1:0] {
    IDLE,
    FWD,
    RESP
  } xbar_state_e;

endpackage

`default_nettype wire

/* src/lite_xbar.sv */
// ----------------------------------------------------------------------
// Two-initiator round-robin crossbar for the lite register bus
// Decodes four address windows, answers unmapped addresses locally
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "lite_subsys_macros.svh"

module lite_xbar (
  input  wire logic                              clk_i,
  input  wire logic                              rst_i,
  input  lite_subsys_pkg::lite_req_t             host_req_i,
  input  lite_subsys_pkg::lite_req_t             cluster_req_i,
  output lite_subsys_pkg::lite_rsp_t             host_rsp_o,
  output lite_subsys_pkg::lite_rsp_t             cluster_rsp_o,
  output lite_subsys_pkg::lite_req_t [3:0]       tgt_req_o,
  input  lite_subsys_pkg::lite_rsp_t [3:0]       tgt_rsp_i
);

  localparam int unsigned WinShift = $clog2(`WIN_SIZE);

  lite_subsys_pkg::xbar_state_e state_q;
  lite_subsys_pkg::xbar_state_e state_d;
  lite_subsys_pkg::tgt_idx_t    tgt_q;
  lite_subsys_pkg::lite_req_t   req_q;
  // 0 selects host, 1 selects cluster
  logic                         owner_q;
  logic                         prio_q;
  logic                         miss_q;

  logic                         idle;
  logic                         gnt_host;
  logic                         gnt_cluster;
  logic                         accept;
  logic                         sel_hit;
  logic                         owner_rsp_ready;
  lite_subsys_pkg::lite_req_t   sel_req;
  lite_subsys_pkg::lite_addr_t  win_off;
  lite_subsys_pkg::lite_rsp_t   sel_rsp;

  assign idle = (state_q == lite_subsys_pkg::IDLE);

  // Priority only matters when both initiators are requesting
  assign gnt_host    = idle && host_req_i.req_valid &&
                       (!cluster_req_i.req_valid || !prio_q);
  assign gnt_cluster = idle && cluster_req_i.req_valid &&
                       (!host_req_i.req_valid || prio_q);
  assign accept      = gnt_host || gnt_cluster;
  assign sel_req     = gnt_cluster ? cluster_req_i : host_req_i;

  assign win_off = sel_req.addr - `WIN_BASE;
  assign sel_hit = (sel_req.addr >= `WIN_BASE) && (win_off < 4 * `WIN_SIZE);

  assign owner_rsp_ready = owner_q ? cluster_req_i.rsp_ready : host_req_i.rsp_ready;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= lite_subsys_pkg::IDLE;
      tgt_q   <= '0;
      owner_q <= 1'b0;
      prio_q  <= 1'b0;
      miss_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        tgt_q   <= win_off[WinShift +: $bits(lite_subsys_pkg::tgt_idx_t)];
        owner_q <= gnt_cluster;
        prio_q  <= !gnt_cluster;
        miss_q  <= !sel_hit;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= sel_req;
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      lite_subsys_pkg::IDLE: begin
        // Unmapped addresses skip the target and answer locally
        if (accept) begin
          state_d = sel_hit ? lite_subsys_pkg::FWD : lite_subsys_pkg::RESP;
        end
      end
      lite_subsys_pkg::FWD: begin
        if (tgt_rsp_i[tgt_q].req_ready) begin
          state_d = lite_subsys_pkg::RESP;
        end
      end
      lite_subsys_pkg::RESP: begin
        if (sel_rsp.rsp_valid && owner_rsp_ready) begin
          state_d = lite_subsys_pkg::IDLE;
        end
      end
      default: state_d = lite_subsys_pkg::IDLE;
    endcase
  end

  // Response of the current transaction, local error for a miss
  always_comb begin
    sel_rsp = tgt_rsp_i[tgt_q];
    if (miss_q) begin
      sel_rsp.rsp_valid = 1'b1;
      sel_rsp.rdata     = '0;
      sel_rsp.err       = 1'b1;
    end
    sel_rsp.rsp_valid = sel_rsp.rsp_valid && (state_q == lite_subsys_pkg::RESP);
  end

  assign host_rsp_o = '{
    req_ready: idle && !gnt_cluster,
    rsp_valid: sel_rsp.rsp_valid && !owner_q,
    rdata:     sel_rsp.rdata,
    err:       sel_rsp.err
  };

  assign cluster_rsp_o = '{
    req_ready: idle && !gnt_host,
    rsp_valid: sel_rsp.rsp_valid && owner_q,
    rdata:     sel_rsp.rdata,
    err:       sel_rsp.err
  };

  // Payload goes to every target, valid only to the decoded one
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      tgt_req_o[i]           = req_q;
      tgt_req_o[i].req_valid = (state_q == lite_subsys_pkg::FWD) &&
                               (tgt_q == lite_subsys_pkg::tgt_idx_t'(i));
      tgt_req_o[i].rsp_ready = (state_q == lite_subsys_pkg::RESP) && !miss_q &&
                               (tgt_q == lite_subsys_pkg::tgt_idx_t'(i)) && owner_rsp_ready;
    end
  end

  // A granted transaction locks out both initiators until it completes
  a_one_grant: assert property (@(posedge clk_i) disable iff (rst_i)
    (host_req_i.req_valid && host_rsp_o.req_ready) ||
    (cluster_req_i.req_valid && cluster_rsp_o.req_ready) |=>
      !host_rsp_o.req_ready && !cluster_rsp_o.req_ready)
    else $error("second initiator granted while a transaction is in flight");

  for (genvar g = 0; g < 4; g++) begin : g_tgt_chk
    a_tgt_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      tgt_req_o[g].req_valid && !tgt_rsp_i[g].req_ready |=>
        tgt_req_o[g].req_valid &&
        $stable({tgt_req_o[g].write, tgt_req_o[g].addr, tgt_req_o[g].wdata}))
      else $error("target %0d request changed before acceptance", g);
  end

endmodule

`default_nettype wire

/* mailbox/lite_mailbox.sv */
// ----------------------------------------------------------------------
// One-direction mailbox on the lite register bus
// Word FIFO with push, pop, fill count and threshold interrupt
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module lite_mailbox #(
  parameter int unsigned Depth = 8
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_i,
  input  lite_subsys_pkg::lite_req_t req_i,
  output lite_subsys_pkg::lite_rsp_t rsp_o,
  output logic                       irq_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  lite_subsys_pkg::lite_data_t mem [Depth];
  logic [PtrW-1:0]             wr_ptr_q;
  logic [PtrW-1:0]             rd_ptr_q;
  logic [CntW-1:0]             count_q;
  lite_subsys_pkg::lite_data_t thresh_q;

  logic                        rsp_valid_q;
  lite_subsys_pkg::lite_data_t rdata_q;
  logic                        err_q;

  lite_subsys_pkg::win_off_t   off;
  logic                        accept;
  logic                        full;
  logic                        empty;
  logic                        push;
  logic                        pop;
  logic                        thr_we;
  lite_subsys_pkg::lite_data_t rdata_d;
  logic                        err_d;

  assign off    = lite_subsys_pkg::win_off_t'(req_i.addr);
  assign accept = req_i.req_valid && !rsp_valid_q;
  assign full   = (count_q == CntW'(Depth));
  assign empty  = (count_q == '0);

  always_comb begin
    push    = 1'b0;
    pop     = 1'b0;
    thr_we  = 1'b0;
    rdata_d = '0;
    err_d   = 1'b0;
    case (off)
      'h0: begin
        if (req_i.write && !full) push = accept;
        else err_d = 1'b1;
      end
      'h4: begin
        if (!req_i.write && !empty) begin
          pop     = accept;
          rdata_d = mem[rd_ptr_q];
        end else begin
          err_d = 1'b1;
        end
      end
      'h8: begin
        if (!req_i.write) rdata_d = lite_subsys_pkg::lite_data_t'(count_q);
        else err_d = 1'b1;
      end
      'hC: begin
        if (req_i.write) thr_we = accept;
        else rdata_d = thresh_q;
      end
      default: err_d = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      count_q     <= '0;
      thresh_q    <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
        count_q  <= count_q + 1'b1;
      end else if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
        count_q  <= count_q - 1'b1;
      end
      if (thr_we) thresh_q <= req_i.wdata;
      // Response stays until the crossbar takes it
      if (accept) rsp_valid_q <= 1'b1;
      else if (req_i.rsp_ready) rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem[wr_ptr_q] <= req_i.wdata;
    if (accept) begin
      rdata_q <= rdata_d;
      err_q   <= err_d;
    end
  end

  assign rsp_o = '{
    req_ready: !rsp_valid_q,
    rsp_valid: rsp_valid_q,
    rdata:     rdata_q,
    err:       err_q
  };

  // A zero threshold keeps the interrupt off
  assign irq_o = (thresh_q != '0) &&
                 (lite_subsys_pkg::lite_data_t'(count_q) >= thresh_q);

  a_fill_bound: assert property (@(posedge clk_i) disable iff (rst_i)
    count_q <= CntW'(Depth))
    else $error("mailbox fill count above depth");

endmodule

`default_nettype wire

/* src/lite_doorbell.sv */
// ----------------------------------------------------------------------
// Doorbell and completion flags with level interrupts
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module lite_doorbell (
  input  wire logic                  clk_i,
  input  wire logic                  rst_i,
  input  lite_subsys_pkg::lite_req_t req_i,
  output lite_subsys_pkg::lite_rsp_t rsp_o,
  output logic                       doorbell_irq_o,
  output logic                       completion_irq_o
);

  logic                        db_q;
  logic                        cmp_q;
  logic                        rsp_valid_q;
  lite_subsys_pkg::lite_data_t rdata_q;
  logic                        err_q;

  lite_subsys_pkg::win_off_t   off;
  logic                        accept;
  logic                        known;

  assign off    = lite_subsys_pkg::win_off_t'(req_i.addr);
  assign accept = req_i.req_valid && !rsp_valid_q;
  assign known  = (off == 'h0) || (off == 'h4) || (off == 'h8);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      db_q        <= 1'b0;
      cmp_q       <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      if (accept && req_i.write) begin
        case (off)
          'h0: db_q <= 1'b1;
          'h4: begin
            // Completion hands the doorbell back
            db_q  <= 1'b0;
            cmp_q <= 1'b1;
          end
          'h8: cmp_q <= 1'b0;
          default: ;
        endcase
      end
      if (accept) rsp_valid_q <= 1'b1;
      else if (req_i.rsp_ready) rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      err_q   <= !known;
      rdata_q <= (known && !req_i.write) ?
                 lite_subsys_pkg::lite_data_t'({cmp_q, db_q}) : '0;
    end
  end

  assign rsp_o = '{
    req_ready: !rsp_valid_q,
    rsp_valid: rsp_valid_q,
    rdata:     rdata_q,
    err:       err_q
  };

  assign doorbell_irq_o   = db_q;
  assign completion_irq_o = cmp_q;

endmodule

`default_nettype wire

/* src/lite_subsystem.sv */
// ----------------------------------------------------------------------
// Lite configuration subsystem top level
// Crossbar, h2c and c2h mailboxes, doorbell block, external cfg port
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "lite_subsys_macros.svh"

module lite_subsystem (
  input  wire logic                  clk_i,
  input  wire logic                  rst_i,
  input  lite_subsys_pkg::lite_req_t host_req_i,
  input  lite_subsys_pkg::lite_req_t cluster_req_i,
  output lite_subsys_pkg::lite_rsp_t host_rsp_o,
  output lite_subsys_pkg::lite_rsp_t cluster_rsp_o,
  output lite_subsys_pkg::lite_req_t cfg_req_o,
  input  lite_subsys_pkg::lite_rsp_t cfg_rsp_i,
  output logic                       h2c_irq_o,
  output logic                       c2h_irq_o,
  output logic                       doorbell_irq_o,
  output logic                       completion_irq_o
);

  // Index is the window number
  lite_subsys_pkg::lite_req_t [3:0] tgt_req;
  lite_subsys_pkg::lite_rsp_t [3:0] tgt_rsp;

  lite_xbar i_xbar (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .host_req_i    ( host_req_i    ),
    .cluster_req_i ( cluster_req_i ),
    .host_rsp_o    ( host_rsp_o    ),
    .cluster_rsp_o ( cluster_rsp_o ),
    .tgt_req_o     ( tgt_req       ),
    .tgt_rsp_i     ( tgt_rsp       )
  );

  // Window 0 leaves the subsystem with the full address
  assign cfg_req_o  = tgt_req[0];
  assign tgt_rsp[0] = cfg_rsp_i;

  lite_mailbox #(
    .Depth ( `MBOX_DEPTH )
  ) i_h2c_mbox (
    .clk_i ( clk_i      ),
    .rst_i ( rst_i      ),
    .req_i ( tgt_req[1] ),
    .rsp_o ( tgt_rsp[1] ),
    .irq_o ( h2c_irq_o  )
  );

  lite_mailbox #(
    .Depth ( `MBOX_DEPTH )
  ) i_c2h_mbox (
    .clk_i ( clk_i      ),
    .rst_i ( rst_i      ),
    .req_i ( tgt_req[2] ),
    .rsp_o ( tgt_rsp[2] ),
    .irq_o ( c2h_irq_o  )
  );

  lite_doorbell i_doorbell (
    .clk_i            ( clk_i            ),
    .rst_i            ( rst_i            ),
    .req_i            ( tgt_req[3]       ),
    .rsp_o            ( tgt_rsp[3]       ),
    .doorbell_irq_o   ( doorbell_irq_o   ),
    .completion_irq_o ( completion_irq_o )
  );

endmodule

`default_nettype wire

/* sim/tb_lite_subsystem.sv */
// ----------------------------------------------------------------------
// Self-checking testbench for the lite configuration subsystem
// Initiator drivers, cfg port responder, reference model, checker
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "lite_subsys_macros.svh"

module tb_lite_subsystem;

  logic                       clk_i;
  logic                       rst_i;
  lite_subsys_pkg::lite_req_t host_req;
  lite_subsys_pkg::lite_req_t cluster_req;
  lite_subsys_pkg::lite_rsp_t host_rsp;
  lite_subsys_pkg::lite_rsp_t cluster_rsp;
  lite_subsys_pkg::lite_req_t cfg_req;
  lite_subsys_pkg::lite_rsp_t cfg_rsp;
  logic                       h2c_irq;
  logic                       c2h_irq;
  logic                       doorbell_irq;
  logic                       completion_irq;

  // Reference state
  lite_subsys_pkg::lite_data_t h2c_q[$];
  lite_subsys_pkg::lite_data_t c2h_q[$];
  lite_subsys_pkg::lite_data_t mbox_thr [2];
  logic                        db_flag;
  logic                        cmp_flag;
  lite_subsys_pkg::lite_data_t ref_mem [16];
  lite_subsys_pkg::lite_data_t ext_mem [16];

  // One outstanding transaction per initiator, index 0 host, 1 cluster
  logic [32:0]                 exp_rsp [2];
  logic                        pending [2];
  lite_subsys_pkg::lite_req_t  exp_cfg;
  int unsigned                 n_issued;
  int unsigned                 n_done;
  int unsigned                 cycles;

  lite_subsystem DUT (
    .clk_i            ( clk_i          ),
    .rst_i            ( rst_i          ),
    .host_req_i       ( host_req       ),
    .cluster_req_i    ( cluster_req    ),
    .host_rsp_o       ( host_rsp       ),
    .cluster_rsp_o    ( cluster_rsp    ),
    .cfg_req_o        ( cfg_req        ),
    .cfg_rsp_i        ( cfg_rsp        ),
    .h2c_irq_o        ( h2c_irq        ),
    .c2h_irq_o        ( c2h_irq        ),
    .doorbell_irq_o   ( doorbell_irq   ),
    .completion_irq_o ( completion_irq )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic stop_run();
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    stop_run();
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_irqs(input logic [3:0] exp);
    check_eq("h2c_irq_o", h2c_irq, exp[0]);
    check_eq("c2h_irq_o", c2h_irq, exp[1]);
    check_eq("doorbell_irq_o", doorbell_irq, exp[2]);
    check_eq("completion_irq_o", completion_irq, exp[3]);
  endtask

  function automatic lite_subsys_pkg::lite_addr_t win_addr(input int unsigned w,
                                                           input int unsigned off);
    return `WIN_BASE + w * `WIN_SIZE + off;
  endfunction

  // Initial cfg memory content, distinct for every word
  function automatic lite_subsys_pkg::lite_data_t mem_fill(input int unsigned i);
    return 32'h5A00_0000 ^ (i * 32'h0010_2041);
  endfunction

  // Expected {err, data} of one access, applied in acceptance order
  function automatic logic [32:0] model_access(input logic wr,
      input lite_subsys_pkg::lite_addr_t addr, input lite_subsys_pkg::lite_data_t wdata);
    lite_subsys_pkg::lite_addr_t rel;
    int unsigned                 w;
    int unsigned                 off;
    int unsigned                 fill;
    lite_subsys_pkg::lite_data_t rd;
    logic                        err;
    rel = addr - `WIN_BASE;
    if (addr < `WIN_BASE || rel >= 4 * `WIN_SIZE) return {1'b1, 32'h0};
    w    = rel / `WIN_SIZE;
    off  = rel % `WIN_SIZE;
    fill = (w == 1) ? h2c_q.size() : c2h_q.size();
    rd   = '0;
    err  = 1'b0;
    if (w == 0) begin
      if (wr) ref_mem[addr[5:2]] = wdata;
      else rd = ref_mem[addr[5:2]];
    end else if (w == 3) begin
      if (off != 'h0 && off != 'h4 && off != 'h8) err = 1'b1;
      else if (!wr) rd = {30'h0, cmp_flag, db_flag};
      else if (off == 'h0) db_flag = 1'b1;
      else if (off == 'h4) begin
        db_flag  = 1'b0;
        cmp_flag = 1'b1;
      end else cmp_flag = 1'b0;
    end else begin
      case (off)
        'h0: begin
          if (!wr || fill >= `MBOX_DEPTH) err = 1'b1;
          else if (w == 1) h2c_q.push_back(wdata);
          else c2h_q.push_back(wdata);
        end
        'h4: begin
          if (wr || fill == 0) err = 1'b1;
          else if (w == 1) rd = h2c_q.pop_front();
          else rd = c2h_q.pop_front();
        end
        'h8: begin
          if (wr) err = 1'b1;
          else rd = fill;
        end
        'hC: begin
          if (wr) mbox_thr[w-1] = wdata;
          else rd = mbox_thr[w-1];
        end
        default: err = 1'b1;
      endcase
    end
    return {err, rd};
  endfunction

  function automatic logic [3:0] model_irqs();
    return {cmp_flag, db_flag,
            mbox_thr[1] != 0 && c2h_q.size() >= mbox_thr[1],
            mbox_thr[0] != 0 && h2c_q.size() >= mbox_thr[0]};
  endfunction

  task automatic check_done(input int unsigned port, input lite_subsys_pkg::lite_req_t req,
                            input lite_subsys_pkg::lite_rsp_t rsp);
    string who;
    who = (port == 1) ? "cluster" : "host";
    if (rsp.rsp_valid && req.rsp_ready) begin
      if (!pending[port]) abort_run({who, " got a response with no request outstanding"});
      check_eq({who, "_rsp_o.err"}, rsp.err, exp_rsp[port][32]);
      check_eq({who, "_rsp_o.rdata"}, rsp.rdata, exp_rsp[port][31:0]);
      check_irqs(model_irqs());
      pending[port] = 1'b0;
      n_done++;
    end
  endtask

  task automatic note_accept(input int unsigned port, input lite_subsys_pkg::lite_req_t req);
    if (pending[port]) abort_run("a request was accepted while its response was outstanding");
    exp_rsp[port] = model_access(req.write, req.addr, req.wdata);
    pending[port] = 1'b1;
    exp_cfg       = req;
  endtask

  // Completions are checked before new acceptances on the same edge
  always @(posedge clk_i) begin
    if (!rst_i) begin
      check_done(0, host_req, host_rsp);
      check_done(1, cluster_req, cluster_rsp);
      if (host_req.req_valid && host_rsp.req_ready) note_accept(0, host_req);
      if (cluster_req.req_valid && cluster_rsp.req_ready) note_accept(1, cluster_req);
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > 40 * n_issued + 100) abort_run("Timeout: a transaction never completed");
  end

  // External cfg port with random accept and answer delays
  initial begin : cfg_responder
    int unsigned                dly;
    lite_subsys_pkg::lite_req_t req;
    cfg_rsp = '0;
    for (int i = 0; i < 16; i++) ext_mem[i] = mem_fill(i);
    forever begin
      @(negedge clk_i);
      if (cfg_req.req_valid) begin
        dly = $urandom_range(3);
        repeat (dly) @(negedge clk_i);
        req               = cfg_req;
        cfg_rsp.req_ready = 1'b1;
        @(negedge clk_i);
        cfg_rsp.req_ready = 1'b0;
        check_eq("cfg_req_o.write", req.write, exp_cfg.write);
        check_eq("cfg_req_o.addr", req.addr, exp_cfg.addr);
        check_eq("cfg_req_o.wdata", req.wdata, exp_cfg.wdata);
        if (req.write) ext_mem[req.addr[5:2]] = req.wdata;
        dly = $urandom_range(3);
        repeat (dly) @(negedge clk_i);
        cfg_rsp.rdata     = req.write ? '0 : ext_mem[req.addr[5:2]];
        cfg_rsp.err       = 1'b0;
        cfg_rsp.rsp_valid = 1'b1;
        do @(posedge clk_i); while (!cfg_req.rsp_ready);
        @(negedge clk_i);
        cfg_rsp.rsp_valid = 1'b0;
      end
    end
  end

  task automatic host_access(input logic wr, input lite_subsys_pkg::lite_addr_t addr,
                             input lite_subsys_pkg::lite_data_t wdata);
    int unsigned dly;
    dly = $urandom_range(3);
    n_issued++;
    host_req.req_valid = 1'b1;
    host_req.write     = wr;
    host_req.addr      = addr;
    host_req.wdata     = wdata;
    do @(posedge clk_i); while (!host_rsp.req_ready);
    @(negedge clk_i);
    host_req.req_valid = 1'b0;
    repeat (dly) @(negedge clk_i);
    host_req.rsp_ready = 1'b1;
    do @(posedge clk_i); while (!host_rsp.rsp_valid);
    @(negedge clk_i);
    host_req.rsp_ready = 1'b0;
  endtask

  task automatic cluster_access(input logic wr, input lite_subsys_pkg::lite_addr_t addr,
                                input lite_subsys_pkg::lite_data_t wdata);
    int unsigned dly;
    dly = $urandom_range(3);
    n_issued++;
    cluster_req.req_valid = 1'b1;
    cluster_req.write     = wr;
    cluster_req.addr      = addr;
    cluster_req.wdata     = wdata;
    do @(posedge clk_i); while (!cluster_rsp.req_ready);
    @(negedge clk_i);
    cluster_req.req_valid = 1'b0;
    repeat (dly) @(negedge clk_i);
    cluster_req.rsp_ready = 1'b1;
    do @(posedge clk_i); while (!cluster_rsp.rsp_valid);
    @(negedge clk_i);
    cluster_req.rsp_ready = 1'b0;
  endtask

  // Host stays on the h2c mailbox and cfg words 0 to 7
  task automatic host_traffic(input int unsigned n);
    lite_subsys_pkg::lite_data_t d;
    int unsigned                 idx;
    for (int unsigned i = 0; i < n; i++) begin
      d   = $urandom;
      idx = $urandom_range(7);
      case ($urandom_range(4))
        0: host_access(1'b1, win_addr(1, 'h0), d);
        1: host_access(1'b0, win_addr(1, 'h4), d);
        2: host_access(1'b0, win_addr(1, 'h8), d);
        3: host_access(1'b1, win_addr(0, idx * 4), d);
        default: host_access(1'b0, win_addr(0, idx * 4), d);
      endcase
    end
  endtask

  // Cluster stays on the c2h mailbox, the doorbell and cfg words 8 to 15
  task automatic cluster_traffic(input int unsigned n);
    lite_subsys_pkg::lite_data_t d;
    int unsigned                 idx;
    for (int unsigned i = 0; i < n; i++) begin
      d   = $urandom;
      idx = $urandom_range(15, 8);
      case ($urandom_range(5))
        0: cluster_access(1'b1, win_addr(2, 'h0), d);
        1: cluster_access(1'b0, win_addr(2, 'h4), d);
        2: cluster_access(1'b1, win_addr(0, idx * 4), d);
        3: cluster_access(1'b0, win_addr(0, idx * 4), d);
        default: cluster_access(d[0], win_addr(3, d[3:2] * 4), d);
      endcase
    end
  endtask

  initial begin
    void'($urandom(32'h3407_97e5));
    rst_i       = 1'b1;
    host_req    = '0;
    cluster_req = '0;
    n_issued    = 0;
    n_done      = 0;
    cycles      = 0;
    pending[0]  = 1'b0;
    pending[1]  = 1'b0;
    mbox_thr[0] = '0;
    mbox_thr[1] = '0;
    db_flag     = 1'b0;
    cmp_flag    = 1'b0;
    for (int i = 0; i < 16; i++) ref_mem[i] = mem_fill(i);
    repeat (3) @(negedge clk_i);
    rst_i = 1'b0;

    check_eq("host_rsp_o.req_ready", host_rsp.req_ready, 1'b1);
    check_eq("cluster_rsp_o.req_ready", cluster_rsp.req_ready, 1'b1);
    check_eq("host_rsp_o.rsp_valid", host_rsp.rsp_valid, 1'b0);
    check_eq("cluster_rsp_o.rsp_valid", cluster_rsp.rsp_valid, 1'b0);
    check_eq("cfg_req_o.req_valid", cfg_req.req_valid, 1'b0);
    check_irqs(4'h0);

    // External window from both initiators
    host_access(1'b1, win_addr(0, 'h8), 32'hCAFE_0001);
    host_access(1'b0, win_addr(0, 'h8), '0);
    cluster_access(1'b0, win_addr(0, 'h8), '0);
    cluster_access(1'b0, win_addr(0, 'hF3C), '0);
    cluster_access(1'b1, win_addr(0, 'h14), 32'h1234_5678);
    host_access(1'b0, win_addr(0, 'h14), '0);

    // Mailbox order and fill count
    cluster_access(1'b0, win_addr(1, 'hC), '0);
    cluster_access(1'b0, win_addr(1, 'h8), '0);
    for (int i = 0; i < 3; i++) host_access(1'b1, win_addr(1, 'h0), 32'hA000_0000 + i);
    cluster_access(1'b0, win_addr(1, 'h8), '0);
    for (int i = 0; i < 3; i++) cluster_access(1'b0, win_addr(1, 'h4), '0);
    for (int i = 0; i < 2; i++) cluster_access(1'b1, win_addr(2, 'h0), 32'hB000_0000 + i);
    for (int i = 0; i < 2; i++) host_access(1'b0, win_addr(2, 'h4), '0);

    // Threshold interrupt
    host_access(1'b1, win_addr(1, 'hC), 32'd2);
    host_access(1'b0, win_addr(1, 'hC), '0);
    host_access(1'b1, win_addr(1, 'h0), 32'h0000_0011);
    host_access(1'b1, win_addr(1, 'h0), 32'h0000_0022);
    cluster_access(1'b0, win_addr(1, 'h4), '0);
    cluster_access(1'b0, win_addr(1, 'h4), '0);
    cluster_access(1'b1, win_addr(2, 'hC), 32'd1);
    cluster_access(1'b1, win_addr(2, 'h0), 32'h0000_0033);
    host_access(1'b0, win_addr(2, 'h4), '0);

    // Error cases leave the state as it was
    for (int i = 0; i < `MBOX_DEPTH; i++) host_access(1'b1, win_addr(1, 'h0), 32'hC000_0000 + i);
    host_access(1'b1, win_addr(1, 'h0), 32'hDEAD_BEEF);
    host_access(1'b0, win_addr(2, 'h4), '0);
    host_access(1'b0, win_addr(1, 'h0), '0);
    host_access(1'b1, win_addr(1, 'h4), 32'h1);
    host_access(1'b1, win_addr(1, 'h8), 32'h1);
    host_access(1'b0, win_addr(1, 'h10), '0);
    host_access(1'b0, win_addr(3, 'hC), '0);
    cluster_access(1'b0, `WIN_BASE - 4, '0);
    cluster_access(1'b1, win_addr(4, 'h0), 32'h5);
    host_access(1'b0, win_addr(1, 'h8), '0);
    for (int i = 0; i < `MBOX_DEPTH; i++) cluster_access(1'b0, win_addr(1, 'h4), '0);

    // Doorbell and completion flags
    host_access(1'b1, win_addr(3, 'h0), '0);
    cluster_access(1'b0, win_addr(3, 'h0), '0);
    cluster_access(1'b1, win_addr(3, 'h4), '0);
    host_access(1'b0, win_addr(3, 'h4), '0);
    host_access(1'b1, win_addr(3, 'h8), '0);
    cluster_access(1'b0, win_addr(3, 'h8), '0);

    fork
      host_traffic(40);
      cluster_traffic(40);
    join

    @(negedge clk_i);
    if (pending[0] || pending[1] || n_done != n_issued) begin
      abort_run("Some transactions did not complete exactly once");
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* lite_subsystem.f */
+incdir+common
common/lite_subsys_pkg.sv
src/lite_xbar.sv
mailbox/lite_mailbox.sv
src/lite_doorbell.sv
src/lite_subsystem.sv
sim/tb_lite_subsystem.sv

/* Bender.yml */
package:
  name: lite_subsystem

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/lite_subsys_pkg.sv
      - src/lite_xbar.sv
      - mailbox/lite_mailbox.sv
      - src/lite_doorbell.sv
      - src/lite_subsystem.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/tb_lite_subsystem.sv
